/* files.f */
+incdir+hdl
hdl/wb_pkg.sv
hdl/wb_addr_decoder.sv
hdl/wb_slave_arbiter.sv
hdl/wb_response_mux.sv
hdl/wb_interconnect.sv
verification/tb_clock_gen.sv
verification/wb_slave_model.sv
verification/wb_interconnect_sva.sv
verification/wb_interconnect_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the Wishbone interconnect testbench with Verilator

LOG=sim.log
BIN=wb_sim

verilator --binary --timing --assert -f files.f --top-module wb_interconnect_tb \
	-Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "Simulation reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "Simulation finished cleanly"
exit 0

/* verification/wb_interconnect_tb.sv */
`include "wb_defines.svh"

module wb_interconnect_tb;

	import wb_pkg::*;

	localparam int CLK_PERIOD = 100;
	// Transfers over all tests, each one gets 20 cycles
	localparam int TOTAL_XFERS = 64 + 16 + 16 + 2 + 72;
	localparam int WATCHDOG_CYCLES = TOTAL_XFERS * 20;

	typedef struct packed {
		logic we;
		logic [3:0] sel;
		logic [3:0] slv;
		logic [3:0] word;
		logic [`WB_DATA_W-1:0] wdata;
		logic [`WB_DATA_W-1:0] rdata;
	} ack_rec_t;

	logic wb_clk;
	logic rst_n;
	logic stall_en;
	wb_mreq_t [`WB_N_MASTERS-1:0] mreq;
	wb_rsp_t [`WB_N_MASTERS-1:0] mrsp;
	wb_sreq_t [`WB_N_SLAVES-1:0] sreq;
	wb_rsp_t [`WB_N_SLAVES-1:0] srsp;

	// Per-master transfer lists, one burst at a time
	wb_mreq_t plan [0:`WB_N_MASTERS-1][0:15];
	int plan_n [0:`WB_N_MASTERS-1];
	time first_ack_t [0:`WB_N_MASTERS-1];
	time drop_t [0:`WB_N_MASTERS-1];

	ack_rec_t ack_q[$];
	logic [3:0] wr_mask [0:`WB_N_SLAVES-1][0:15];
	logic [`WB_DATA_W-1:0] wr_data [0:`WB_N_SLAVES-1][0:15];
	int fail_count;

	tb_clock_gen u_clk (
		.wb_clk_o(wb_clk)
	);

	wb_interconnect DUT (
		.wb_clk_i(wb_clk),
		.rst_n_i(rst_n),
		.mreq_i(mreq),
		.mrsp_o(mrsp),
		.sreq_o(sreq),
		.srsp_i(srsp)
	);

	for (genvar s = 0; s < `WB_N_SLAVES; s++) begin : g_slv
		wb_slave_model #(
			.SLAVE_ID(s)
		) u_slave (
			.wb_clk_i(wb_clk),
			.rst_n_i(rst_n),
			.stall_en_i(stall_en),
			.req_i(sreq[s]),
			.rsp_o(srsp[s])
		);
	end

	task automatic report_failure(input string why);
		fail_count++;
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("ERROR at %0t: %s, got %h expected %h",
				$time, what, got, exp));
		end
	endtask

	// Initial pattern merged with every byte written so far
	function automatic logic [31:0] expected_read(input int slv, input int word);
		logic [31:0] value;
		value = {8'(slv), 24'(word)};
		for (int b = 0; b < 4; b++) begin
			if (wr_mask[slv][word][b]) begin
				value[8*b +: 8] = wr_data[slv][word][8*b +: 8];
			end
		end
		return value;
	endfunction

	task automatic add_xfer(input int m, input int slv, input int word, input logic we,
			input logic [3:0] sel, input logic [31:0] data);
		wb_mreq_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we = we;
		r.sel = sel;
		r.data = data;
		r.adr = {4'(slv), 24'(word)};
		plan[m][plan_n[m]] = r;
		plan_n[m]++;
	endtask

	task automatic add_write_read(input int m, input int slv, input int n);
		int words [0:7];
		for (int i = 0; i < n; i++) begin
			words[i] = $urandom_range(15);
			add_xfer(m, slv, words[i], 1'b1, 4'($urandom_range(15)), $urandom);
		end
		for (int i = 0; i < n; i++) begin
			add_xfer(m, slv, words[i], 1'b0, 4'hf, 32'h0);
		end
	endtask

	// One cycle per burst, strobes advance on stall low, acks counted in order
	task automatic run_master(input int m);
		int n;
		int sent;
		int acks;
		logic stb_on;
		logic accepted;
		wb_rsp_t rsp;
		ack_rec_t rec;
		wb_mreq_t cur;
		n = plan_n[m];
		sent = 0;
		acks = 0;
		@(posedge wb_clk);
		mreq[m] <= plan[m][0];
		stb_on = 1'b1;
		while (acks < n) begin
			@(negedge wb_clk);
			rsp = mrsp[m];
			accepted = stb_on && !rsp.stall;
			if (rsp.ack) begin
				check_equal("ack matches an accepted strobe",
					32'(acks < sent + int'(accepted)), 32'd1);
				check_equal("err on mapped ack", 32'(rsp.err), 32'd0);
				cur = plan[m][acks];
				rec.we = cur.we;
				rec.sel = cur.sel;
				rec.slv = cur.adr[27:24];
				rec.word = cur.adr[3:0];
				rec.wdata = cur.data;
				rec.rdata = rsp.data;
				ack_q.push_back(rec);
				if (acks == 0) begin
					first_ack_t[m] = $time;
				end
				acks++;
			end
			@(posedge wb_clk);
			if (accepted) begin
				sent++;
			end
			if (acks == n) begin
				mreq[m] <= '0;
				drop_t[m] = $time;
			end else if (accepted) begin
				if (sent < n) begin
					mreq[m] <= plan[m][sent];
				end else begin
					mreq[m].stb <= 1'b0;
					stb_on = 1'b0;
				end
			end
		end
		plan_n[m] = 0;
	endtask

	task automatic random_traffic(input int m);
		int slv;
		int len;
		for (int b = 0; b < 6; b++) begin
			slv = $urandom_range(3);
			len = $urandom_range(4, 1);
			for (int i = 0; i < len; i++) begin
				add_xfer(m, slv, $urandom_range(15), 1'($urandom_range(1)),
					4'($urandom_range(15)), $urandom);
			end
			run_master(m);
		end
	endtask

	task automatic check_quiet_slaves(input string what);
		for (int s = 0; s < `WB_N_SLAVES; s++) begin
			check_equal(what, 32'({sreq[s].cyc, sreq[s].stb}), 32'd0);
		end
	endtask

	task automatic unmapped_access(input int idx);
		wb_mreq_t r;
		r = '0;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.adr = {4'(idx), 24'h000005};
		@(posedge wb_clk);
		mreq[2] <= r;
		@(negedge wb_clk);
		check_equal("unmapped ack", 32'(mrsp[2].ack), 32'd1);
		check_equal("unmapped data", mrsp[2].data, 32'd0);
		check_equal("unmapped err", 32'(mrsp[2].err), 32'd0);
		check_quiet_slaves("slave cyc on unmapped access");
		@(posedge wb_clk);
		mreq[2] <= '0;
	endtask

	// Compare process, replays acks in order against the shadow memory
	initial begin
		ack_rec_t rec;
		forever begin
			@(posedge wb_clk);
			while (ack_q.size() > 0) begin
				rec = ack_q.pop_front();
				if (rec.we) begin
					for (int b = 0; b < 4; b++) begin
						if (rec.sel[b]) begin
							wr_mask[rec.slv][rec.word][b] = 1'b1;
							wr_data[rec.slv][rec.word][8*b +: 8] = rec.wdata[8*b +: 8];
						end
					end
				end else begin
					check_equal($sformatf("read slave %0d word %0d", rec.slv, rec.word),
						rec.rdata, expected_read(int'(rec.slv), int'(rec.word)));
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		report_failure("Watchdog expired, the run hung before all transfers completed");
	end

	initial begin
		void'($urandom(32'h5941));
		mreq <= '0;
		stall_en <= 1'b0;
		rst_n <= 1'b0;
		fail_count = 0;
		for (int s = 0; s < `WB_N_SLAVES; s++) begin
			for (int w = 0; w < 16; w++) begin
				wr_mask[s][w] = 4'h0;
				wr_data[s][w] = '0;
			end
		end
		for (int m = 0; m < `WB_N_MASTERS; m++) begin
			plan_n[m] = 0;
		end
		repeat (2) @(posedge wb_clk);
		rst_n <= 1'b1;

		// Idle after reset
		@(negedge wb_clk);
		check_quiet_slaves("slave cyc or stb after reset");
		for (int m = 0; m < `WB_N_MASTERS; m++) begin
			check_equal("master ack after reset", 32'(mrsp[m].ack), 32'd0);
		end

		// Single master over every slave
		for (int s = 0; s < `WB_N_SLAVES; s++) begin
			add_write_read(0, s, 8);
			run_master(0);
		end

		// Same slave, same cycle
		repeat (2) @(posedge wb_clk);
		add_write_read(0, 2, 4);
		add_write_read(1, 2, 4);
		fork
			run_master(0);
			run_master(1);
		join
		check_equal("master 1 waits for master 0 to drop cyc",
			32'(first_ack_t[1] > drop_t[0]), 32'd1);

		// Different slaves run side by side
		repeat (2) @(posedge wb_clk);
		add_write_read(0, 1, 4);
		add_write_read(2, 3, 4);
		fork
			run_master(0);
			run_master(2);
		join
		check_equal("parallel first ack", 32'(first_ack_t[0] == first_ack_t[2]), 32'd1);
		check_equal("parallel completion", 32'(drop_t[0] == drop_t[2]), 32'd1);

		unmapped_access(4);
		unmapped_access(15);

		// Mixed traffic under random slave stalls
		stall_en <= 1'b1;
		fork
			random_traffic(0);
			random_traffic(1);
			random_traffic(2);
		join
		stall_en <= 1'b0;

		repeat (4) @(posedge wb_clk);
		check_equal("acks left unchecked", 32'(ack_q.size()), 32'd0);
		if (fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			report_failure("Errors were recorded during the run");
		end
	end

endmodule

/* verification/wb_interconnect_sva.sv */
`include "wb_defines.svh"

module wb_interconnect_sva (
	input logic wb_clk_i,
	input logic rst_n_i,
	input logic [`WB_N_MASTERS-1:0] req_i,
	input wb_pkg::wb_mreq_t [`WB_N_MASTERS-1:0] mreq_i,
	input wb_pkg::wb_grant_t grant_i,
	input wb_pkg::wb_sreq_t sreq_i
);

	import wb_pkg::*;

	// No slave cycle unless its owner is itself inside a cycle
	a_cyc_needs_grant: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		sreq_i.cyc |-> grant_i.valid && mreq_i[grant_i.midx].cyc)
		else $error("slave cyc high without a granted master in a cycle");

	// Holder keeps the slave as long as it asks for it
	a_grant_locked: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
		grant_i.valid && req_i[grant_i.midx] |=> grant_i == $past(grant_i))
		else $error("grant changed while the holder still requested");

endmodule

bind wb_slave_arbiter wb_interconnect_sva u_sva (
	.wb_clk_i(wb_clk_i),
	.rst_n_i(rst_n_i),
	.req_i(req_i),
	.mreq_i(mreq_i),
	.grant_i(grant_o),
	.sreq_i(sreq_o)
);

/* verification/wb_slave_model.sv */
`include "wb_defines.svh"

module wb_slave_model #(
	parameter int SLAVE_ID = 0
) (
	input logic wb_clk_i,
	input logic rst_n_i,
	input logic stall_en_i,
	input wb_pkg::wb_sreq_t req_i,
	output wb_pkg::wb_rsp_t rsp_o
);

	import wb_pkg::*;

	logic [`WB_DATA_W-1:0] mem [0:15];
	logic stall_q;
	logic ack_q;
	logic [`WB_DATA_W-1:0] rdata_q;
	logic accept;

	assign accept = req_i.cyc && req_i.stb && !stall_q;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			stall_q <= 1'b0;
			ack_q <= 1'b0;
			rdata_q <= '0;
			// Slave index on top, word address below
			for (int w = 0; w < 16; w++) begin
				mem[w] <= {8'(SLAVE_ID), 24'(w)};
			end
		end else begin
			stall_q <= stall_en_i && ($urandom_range(3) == 0);
			ack_q <= accept;
			if (accept) begin
				if (req_i.we) begin
					for (int b = 0; b < `WB_SEL_W; b++) begin
						if (req_i.sel[b]) begin
							mem[req_i.adr[3:0]][8*b +: 8] <= req_i.data[8*b +: 8];
						end
					end
					rdata_q <= '0;
				end else begin
					rdata_q <= mem[req_i.adr[3:0]];
				end
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.stall = stall_q;
	assign rsp_o.err = 1'b0;
	assign rsp_o.data = rdata_q;

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
	output logic wb_clk_o
);

	localparam int HALF_PERIOD = 50;

	initial begin
		wb_clk_o = 1'b0;
		forever begin
			#HALF_PERIOD;
			wb_clk_o = ~wb_clk_o;
		end
	end

endmodule

/* hdl/wb_interconnect.sv */
`include "wb_defines.svh"

module wb_interconnect (
	input logic wb_clk_i,
	input logic rst_n_i,
	input wb_pkg::wb_mreq_t [`WB_N_MASTERS-1:0] mreq_i,
	output wb_pkg::wb_rsp_t [`WB_N_MASTERS-1:0] mrsp_o,
	output wb_pkg::wb_sreq_t [`WB_N_SLAVES-1:0] sreq_o,
	input wb_pkg::wb_rsp_t [`WB_N_SLAVES-1:0] srsp_i
);

	import wb_pkg::*;

	// Decoder outputs, one row per master
	logic [`WB_N_MASTERS-1:0][`WB_IDX_W-1:0] slave_idx;
	logic [`WB_N_MASTERS-1:0] mapped;
	logic [`WB_N_MASTERS-1:0][`WB_N_SLAVES-1:0] slave_req;

	// Same requests regrouped per slave
	logic [`WB_N_SLAVES-1:0][`WB_N_MASTERS-1:0] arb_req;

	wb_grant_t [`WB_N_SLAVES-1:0] grants;

	genvar m;
	genvar s;

	generate
		for (m = 0; m < `WB_N_MASTERS; m++) begin : g_master
			wb_addr_decoder u_dec (
				.req_i(mreq_i[m]),
				.slave_idx_o(slave_idx[m]),
				.mapped_o(mapped[m]),
				.slave_req_o(slave_req[m])
			);

			wb_response_mux #(
				.MASTER_ID(m)
			) u_mux (
				.slave_idx_i(slave_idx[m]),
				.mapped_i(mapped[m]),
				.cyc_i(mreq_i[m].cyc),
				.grants_i(grants),
				.srsp_i(srsp_i),
				.rsp_o(mrsp_o[m])
			);
		end

		// Transpose master rows into per-slave request vectors
		for (s = 0; s < `WB_N_SLAVES; s++) begin : g_req_swap
			for (m = 0; m < `WB_N_MASTERS; m++) begin : g_bit
				assign arb_req[s][m] = slave_req[m][s];
			end
		end

		for (s = 0; s < `WB_N_SLAVES; s++) begin : g_slave
			wb_slave_arbiter u_arb (
				.wb_clk_i(wb_clk_i),
				.rst_n_i(rst_n_i),
				.req_i(arb_req[s]),
				.mreq_i(mreq_i),
				.grant_o(grants[s]),
				.sreq_o(sreq_o[s])
			);
		end
	endgenerate

endmodule

/* hdl/wb_response_mux.sv */
`include "wb_defines.svh"

module wb_response_mux #(
	parameter int MASTER_ID = 0
) (
	input logic [`WB_IDX_W-1:0] slave_idx_i,
	input logic mapped_i,
	input logic cyc_i,
	input wb_pkg::wb_grant_t [`WB_N_SLAVES-1:0] grants_i,
	input wb_pkg::wb_rsp_t [`WB_N_SLAVES-1:0] srsp_i,
	output wb_pkg::wb_rsp_t rsp_o
);

	import wb_pkg::*;

	localparam int NUM_SLAVES = `WB_N_SLAVES;

	wb_rsp_t sel_rsp;
	logic owned;

	// Addressed slave and whether its grant names us
	always_comb begin
		sel_rsp = '0;
		owned = 1'b0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (int'(slave_idx_i) == s) begin
				sel_rsp = srsp_i[s];
				owned = grants_i[s].valid && (int'(grants_i[s].midx) == MASTER_ID);
			end
		end
	end

	always_comb begin
		if (!mapped_i) begin
			// Nothing behind this index, answer right away
			rsp_o.ack = cyc_i;
			rsp_o.stall = 1'b0;
			rsp_o.err = 1'b0;
			rsp_o.data = '0;
		end else if (owned) begin
			rsp_o = sel_rsp;
		end else begin
			// Slave busy with another master or grant not yet in place
			rsp_o.ack = 1'b0;
			rsp_o.stall = 1'b1;
			rsp_o.err = 1'b0;
			rsp_o.data = '0;
		end
	end

endmodule

/* hdl/wb_slave_arbiter.sv */
`include "wb_defines.svh"

module wb_slave_arbiter (
	input logic wb_clk_i,
	input logic rst_n_i,
	input logic [`WB_N_MASTERS-1:0] req_i,
	input wb_pkg::wb_mreq_t [`WB_N_MASTERS-1:0] mreq_i,
	output wb_pkg::wb_grant_t grant_o,
	output wb_pkg::wb_sreq_t sreq_o
);

	import wb_pkg::*;

	localparam int NUM_MASTERS = `WB_N_MASTERS;

	wb_grant_t grant_q;
	wb_grant_t grant_d;

	logic any_req;
	logic [`WB_MIDX_W-1:0] pick_idx;
	logic holder_req;
	wb_mreq_t sel_req;

	// Lowest index among requesters
	always_comb begin
		any_req = |req_i;
		pick_idx = '0;
		for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
			if (req_i[m]) begin
				pick_idx = m[`WB_MIDX_W-1:0];
			end
		end
	end

	// Holder still wants this slave
	always_comb begin
		holder_req = 1'b0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (grant_q.valid && (grant_q.midx == m[`WB_MIDX_W-1:0]) && req_i[m]) begin
				holder_req = 1'b1;
			end
		end
	end

	// Locked grant, re-arbitrate only once the holder lets go
	always_comb begin
		grant_d = grant_q;
		if (!holder_req) begin
			grant_d.valid = any_req;
			grant_d.midx = pick_idx;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			grant_q <= '0;
		end else begin
			grant_q <= grant_d;
		end
	end

	assign grant_o = grant_q;

	// Fields of the current holder
	always_comb begin
		sel_req = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (grant_q.midx == m[`WB_MIDX_W-1:0]) begin
				sel_req = mreq_i[m];
			end
		end
	end

	// Request path to the slave
	// cyc and stb are qualified, the payload follows the holder as is
	always_comb begin
		sreq_o.cyc = holder_req;
		sreq_o.stb = holder_req && sel_req.stb;
		sreq_o.we = sel_req.we;
		sreq_o.sel = sel_req.sel;
		sreq_o.data = sel_req.data;
		sreq_o.adr = sel_req.adr[`WB_SLV_ADR_W-1:0];
	end

endmodule

/* hdl/wb_addr_decoder.sv */
`include "wb_defines.svh"

module wb_addr_decoder (
	input wb_pkg::wb_mreq_t req_i,
	output logic [`WB_IDX_W-1:0] slave_idx_o,
	output logic mapped_o,
	output logic [`WB_N_SLAVES-1:0] slave_req_o
);

	localparam int NUM_SLAVES = `WB_N_SLAVES;

	logic [`WB_IDX_W-1:0] idx;
	logic in_range;

	// Upper address bits select the slave
	assign idx = req_i.adr[`WB_ADR_W-1:`WB_SLV_ADR_W];

	// Indices past the last slave have nothing behind them
	assign in_range = int'(idx) < NUM_SLAVES;

	assign slave_idx_o = idx;
	assign mapped_o = in_range;

	// One-hot request toward the addressed slave, only inside a cycle
	always_comb begin
		slave_req_o = '0;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (req_i.cyc && in_range && (int'(idx) == s)) begin
				slave_req_o[s] = 1'b1;
			end
		end
	end

endmodule

/* hdl/wb_pkg.sv */
`include "wb_defines.svh"

package wb_pkg;

	// Request as driven by a master, full address
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_SEL_W-1:0] sel;
		logic [`WB_DATA_W-1:0] data;
		logic [`WB_ADR_W-1:0] adr;
	} wb_mreq_t;

	// Request toward a slave, slave index already stripped
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_SEL_W-1:0] sel;
		logic [`WB_DATA_W-1:0] data;
		logic [`WB_SLV_ADR_W-1:0] adr;
	} wb_sreq_t;

	// Return path, same shape on both sides
	typedef struct packed {
		logic ack;
		logic stall;
		logic err;
		logic [`WB_DATA_W-1:0] data;
	} wb_rsp_t;

	// Which master currently owns a slave
	typedef struct packed {
		logic valid;
		logic [`WB_MIDX_W-1:0] midx;
	} wb_grant_t;

endpackage

/* hdl/wb_defines.svh */
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

// Data path
`define WB_DATA_W 32
`define WB_SEL_W 4

// Master side address, upper field picks the slave
`define WB_ADR_W 28

// Address as seen by a slave
`define WB_SLV_ADR_W 24

// Slave index field on top of the master address
`define WB_IDX_W 4

// Port counts
`define WB_N_MASTERS 3
`define WB_N_SLAVES 4

// Wide enough to name any master
`define WB_MIDX_W 2

`endif
